/* rom_slots.f */
src/rom_pkg.sv
src/rom_slot_if.sv
src/rom_slot.sv
src/rom_arbiter.sv
src/rom_slots.sv
bench/sdram_model.sv
bench/tb_rom_slots.sv

/* bench/tb_rom_slots.sv */
// rom slots testbench
`default_nettype none
`timescale 1ns/1ps

module tb_rom_slots import rom_pkg::*; ();

    localparam int num_access     = 150;
    localparam int timeout_cycles = 200;
    localparam int finish_limit   = num_access * (timeout_cycles + 8);

    logic        clk;
    logic        rst;
    logic        slot_cs   [num_slots];
    slot_addr_t  slot_addr [num_slots];
    slot_data_t  slot_dout [num_slots];
    logic        slot_ok   [num_slots];
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack;
    logic        data_rdy;
    sdram_data_t data_read;

    integer seed = 67230;
    int     client_seed [num_slots];
    int     cycle = 0;

    // reference model with one cache tag per slot
    logic               ref_valid   [num_slots];
    logic [slot_aw-1:1] ref_tag     [num_slots];
    logic               waiting     [num_slots];
    int                 miss_cycle  [num_slots];
    logic               client_done [num_slots];

    // values seen at the previous falling edge
    slot_addr_t  prev_addr [num_slots];
    logic        prev_req = 1'b0;
    logic        prev_ack = 1'b0;
    sdram_addr_t prev_sdram_addr;

    int data_checks = 0;
    int grant_checks = 0;
    int data_errs = 0;
    int cache_errs = 0;
    int prio_errs = 0;
    int stable_errs = 0;
    int starve_errs = 0;
    int reset_errs = 0;

    rom_slots i_rom_slots (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .slot_cs    ( slot_cs    ),
        .slot_addr  ( slot_addr  ),
        .slot_dout  ( slot_dout  ),
        .slot_ok    ( slot_ok    ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    sdram_model i_sdram_model (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic slot_data_t rom_word(input sdram_addr_t a);
        return a[15:0] ^ 16'ha5c3;
    endfunction

    function automatic int region_of(input sdram_addr_t a);
        int r;
        r = 0;
        for (int i = 1; i < num_slots; i++) begin
            if (a >= slot_offset[i]) begin
                r = i;
            end
        end
        return r;
    endfunction

    // one client with addresses that repeat or stay near the last one
    task automatic run_client(input int s, input int start_seed);
        integer     lseed;
        slot_addr_t a;
        slot_addr_t last;
        int         pick;
        int         gap;
        int         wait_cnt;
        int         base_cnt;
        logic       exp_hit;
        lseed = start_seed;
        last  = slot_addr_t'($random(lseed));
        @(posedge clk);
        for (int n = 0; n < num_access; n++) begin
            pick = $unsigned($random(lseed)) % 8;
            if (pick < 3) begin
                a = last;
            end else if (pick < 5) begin
                // other half of the same line
                a = last ^ slot_addr_t'(1);
            end else if (pick < 6) begin
                a = last + slot_addr_t'(2);
            end else begin
                a = slot_addr_t'($random(lseed));
            end
            gap = $unsigned($random(lseed)) % 4;
            if (gap != 0) begin
                slot_cs[s] <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            exp_hit = ref_valid[s] && (ref_tag[s] == a[slot_aw-1:1]);
            slot_cs[s]   <= 1'b1;
            slot_addr[s] <= a;
            @(negedge clk);
            base_cnt = i_sdram_model.region_count[s];
            if (!exp_hit) begin
                waiting[s]    = 1'b1;
                miss_cycle[s] = cycle;
            end
            // ok in this cycle still belongs to the previous address
            @(negedge clk);
            wait_cnt = 0;
            while (!slot_ok[s] && wait_cnt < timeout_cycles) begin
                @(negedge clk);
                wait_cnt++;
            end
            assert (slot_ok[s]) else begin
                starve_errs++;
                $display("slot %0d starved, address %h got no ok within %0d cycles",
                         s, a, timeout_cycles);
            end
            if (exp_hit) begin
                assert (i_sdram_model.region_count[s] == base_cnt) else begin
                    cache_errs++;
                    $display("Fail %0t: slot %0d hit at %h still read sdram", $time, s, a);
                end
            end else begin
                ref_valid[s] = 1'b1;
                ref_tag[s]   = a[slot_aw-1:1];
            end
            last = a;
            @(posedge clk);
        end
        slot_cs[s] <= 1'b0;
        client_done[s] = 1'b1;
    endtask

    // data, request stability and priority monitor
    always @(negedge clk) begin
        slot_data_t want;
        int         r;
        if (!rst) begin
            for (int i = 0; i < num_slots; i++) begin
                if (slot_ok[i]) begin
                    data_checks++;
                    want = rom_word(slot_offset[i] + prev_addr[i]);
                    assert (slot_dout[i] == want) else begin
                        data_errs++;
                        $display("Fail %0t: slot %0d addr %h dout %h, expected %h",
                                 $time, i, prev_addr[i], slot_dout[i], want);
                    end
                end
            end
            if (prev_req && !prev_ack) begin
                assert (sdram_req && sdram_addr == prev_sdram_addr) else begin
                    stable_errs++;
                    $display("Fail %0t: sdram request changed before ack", $time);
                end
            end
            if (sdram_req && !prev_req) begin
                grant_checks++;
                r = region_of(sdram_addr);
                assert (sdram_addr[0] == 1'b0) else begin
                    stable_errs++;
                    $display("Fail %0t: odd sdram address %h", $time, sdram_addr);
                end
                for (int j = 0; j < r; j++) begin
                    assert (!(waiting[j] && miss_cycle[j] <= cycle - 2)) else begin
                        prio_errs++;
                        $display("Fail %0t: slot %0d granted while slot %0d waits",
                                 $time, r, j);
                    end
                end
                waiting[r] = 1'b0;
            end
        end
        for (int i = 0; i < num_slots; i++) begin
            prev_addr[i] = slot_addr[i];
        end
        prev_req        = sdram_req;
        prev_ack        = sdram_ack;
        prev_sdram_addr = sdram_addr;
    end

    initial begin
        int   wait_cnt;
        int   total;
        logic all_done;
        clk = 1'b0;
        rst <= 1'b1;
        for (int i = 0; i < num_slots; i++) begin
            slot_cs[i]     <= 1'b0;
            slot_addr[i]   <= '0;
            ref_valid[i]   = 1'b0;
            ref_tag[i]     = '0;
            waiting[i]     = 1'b0;
            miss_cycle[i]  = 0;
            client_done[i] = 1'b0;
            client_seed[i] = $random(seed);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!sdram_req) else begin
            reset_errs++;
            $display("Fail %0t: sdram_req high after reset", $time);
        end
        for (int i = 0; i < num_slots; i++) begin
            assert (!slot_ok[i]) else begin
                reset_errs++;
                $display("Fail %0t: slot_ok[%0d] high after reset", $time, i);
            end
        end
        for (int i = 0; i < num_slots; i++) begin
            fork
                automatic int s = i;
                run_client(s, client_seed[s]);
            join_none
        end
        wait_cnt = 0;
        all_done = 1'b0;
        while (!all_done && wait_cnt < finish_limit) begin
            @(negedge clk);
            wait_cnt++;
            all_done = 1'b1;
            for (int i = 0; i < num_slots; i++) begin
                if (!client_done[i]) begin
                    all_done = 1'b0;
                end
            end
        end
        assert (all_done) else begin
            starve_errs++;
            $display("clients did not finish within %0d cycles", finish_limit);
        end
        total = data_errs + cache_errs + prio_errs + stable_errs + starve_errs + reset_errs;
        $write("checks: %0d data, %0d grants, %0d sdram reads; ",
               data_checks, grant_checks, i_sdram_model.grant_log.size());
        $write("errors: data %0d, cache %0d, priority %0d, ",
               data_errs, cache_errs, prio_errs);
        $display("stability %0d, progress %0d, reset %0d",
                 stable_errs, starve_errs, reset_errs);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/sdram_model.sv */
// sdram controller model
`default_nettype none
`timescale 1ns/1ps

module sdram_model import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output sdram_data_t data_read
);

    typedef enum logic [1:0] {
        m_idle,
        m_ack,
        m_data
    } model_state_t;

    integer       seed = 67230;
    model_state_t state;
    int           delay;
    sdram_addr_t  cur_addr;

    // request statistics, read by the testbench
    int           region_count [num_slots];
    sdram_addr_t  grant_log [$];

    // contents follow the address
    function automatic slot_data_t word_at(input sdram_addr_t a);
        return a[15:0] ^ 16'ha5c3;
    endfunction

    function automatic int owner_slot(input sdram_addr_t a);
        int r;
        r = 0;
        for (int i = 1; i < num_slots; i++) begin
            if (a >= slot_offset[i]) begin
                r = i;
            end
        end
        return r;
    endfunction

    always @(posedge clk or posedge rst) begin
        int d;
        int r;
        if (rst) begin
            state     <= m_idle;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            delay     <= 0;
            cur_addr  <= '0;
            for (int i = 0; i < num_slots; i++) begin
                region_count[i] <= 0;
            end
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            case (state)
                m_idle: begin
                    if (sdram_req) begin
                        r = owner_slot(sdram_addr);
                        region_count[r] <= region_count[r] + 1;
                        grant_log.push_back(sdram_addr);
                        d = $unsigned($random(seed)) % 5;
                        if (d == 0) begin
                            // ack right away
                            sdram_ack <= 1'b1;
                            cur_addr  <= sdram_addr;
                            delay     <= $unsigned($random(seed)) % 5;
                            state     <= m_data;
                        end else begin
                            delay <= d - 1;
                            state <= m_ack;
                        end
                    end
                end
                m_ack: begin
                    if (delay == 0) begin
                        sdram_ack <= 1'b1;
                        cur_addr  <= sdram_addr;
                        delay     <= $unsigned($random(seed)) % 5;
                        state     <= m_data;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                m_data: begin
                    if (delay == 0) begin
                        // even word in the low half
                        data_rdy  <= 1'b1;
                        data_read <= {word_at(cur_addr + 1'b1), word_at(cur_addr)};
                        state     <= m_idle;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                default: begin
                    state <= m_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/rom_slots.sv */
// rom slots top level
`default_nettype none
`timescale 1ns/1ps

module rom_slots import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // client ports, one entry per slot
    input  logic        slot_cs   [num_slots],
    input  slot_addr_t  slot_addr [num_slots],
    output slot_data_t  slot_dout [num_slots],
    output logic        slot_ok   [num_slots],

    // sdram controller
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_data_t data_read
);

    rom_slot_if slot_bus [num_slots] ();

    // slot 0 sits closest to the arbiter priority
    for (genvar i = 0; i < num_slots; i++) begin : g_slot
        rom_slot #(
            .slot_offset_v ( slot_offset[i] )
        ) u_slot (
            .clk  ( clk          ),
            .rst  ( rst          ),
            .cs   ( slot_cs[i]   ),
            .addr ( slot_addr[i] ),
            .dout ( slot_dout[i] ),
            .ok   ( slot_ok[i]   ),
            .bus  ( slot_bus[i]  )
        );
    end

    rom_arbiter u_arbiter (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .slots      ( slot_bus   ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

endmodule

`default_nettype wire

/* src/rom_arbiter.sv */
// fixed-priority sdram arbiter
`default_nettype none
`timescale 1ns/1ps

module rom_arbiter import rom_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    rom_slot_if.arbiter   slots [num_slots],
    output logic          sdram_req,
    output sdram_addr_t   sdram_addr,
    input  logic          sdram_ack,
    input  logic          data_rdy,
    input  sdram_data_t   data_read
);

    arb_state_t  arb_state;
    slot_sel_t   sel;

    slot_sel_t   req_vec;
    sdram_addr_t addr_vec [num_slots];

    slot_sel_t   active;
    slot_sel_t   grant;
    sdram_addr_t grant_addr;
    logic        grant_pt;

    // flatten the slot links so they can be indexed
    for (genvar i = 0; i < num_slots; i++) begin : g_link
        assign req_vec[i]     = slots[i].req;
        assign addr_vec[i]    = slots[i].addr;
        assign slots[i].sel   = sel[i];
        assign slots[i].rdata = data_read;
        assign slots[i].rdy   = data_rdy && sel[i];
    end

    // new grant when idle or as the current read completes
    assign grant_pt = (arb_state == arb_idle) || data_rdy;

    // the slot being completed still shows req this cycle
    assign active = req_vec & ~sel;

    // lowest set bit wins
    assign grant = active & (~active + 1'b1);

    always_comb begin
        grant_addr = '0;
        for (int i = 0; i < num_slots; i++) begin
            if (grant[i]) begin
                grant_addr = addr_vec[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arb_state <= arb_idle;
            sel       <= '0;
            sdram_req <= 1'b0;
        end else begin
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (grant_pt) begin
                sel       <= grant;
                sdram_req <= |grant;
                arb_state <= (|grant) ? arb_busy : arb_idle;
            end
        end
    end

    // address only loads with a new grant
    always_ff @(posedge clk) begin
        if (grant_pt && |grant) begin
            sdram_addr <= grant_addr;
        end
    end

    // at most one slot is selected and it still requests
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(sel) && ((sel & ~req_vec) == '0)
    ) else $error("select register not one-hot or slot not requesting");

    // controller may latch the address any time before ack
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (sdram_req && !sdram_ack) |=> $stable(sdram_addr)
    ) else $error("sdram_addr moved before ack");

endmodule

`default_nettype wire

/* src/rom_slot.sv */
// rom slot with one-line cache
`default_nettype none
`timescale 1ns/1ps

module rom_slot import rom_pkg::*; #(
    parameter sdram_addr_t slot_offset_v = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  slot_addr_t  addr,
    output slot_data_t  dout,
    output logic        ok,
    rom_slot_if.slot    bus
);

    slot_state_t state;

    // cache line whose tag drops the word select bit
    logic                 valid;
    logic [slot_aw-1:1]   tag;
    sdram_data_t          line;

    // address of the fetch in flight
    slot_addr_t           pend_addr;
    sdram_addr_t          fetch_addr;
    logic                 fetch_req;

    logic hit;
    logic lookup;
    logic miss_start;
    logic fill;

    assign hit        = valid && (tag == addr[slot_aw-1:1]);
    // st_fill looks up like st_idle since the line is already written
    assign lookup     = (state != st_wait);
    assign miss_start = lookup && cs && !hit;
    assign fill       = (state == st_wait) && bus.rdy;

    assign bus.req  = fetch_req;
    assign bus.addr = fetch_addr;

    // control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            ok        <= 1'b0;
            fetch_req <= 1'b0;
            valid     <= 1'b0;
        end else begin
            case (state)
                st_idle, st_fill: begin
                    ok <= cs && hit;
                    if (miss_start) begin
                        state     <= st_wait;
                        fetch_req <= 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_wait: begin
                    if (bus.rdy) begin
                        state     <= st_fill;
                        fetch_req <= 1'b0;
                        valid     <= 1'b1;
                        // client may have given up while waiting
                        ok        <= cs;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // cache line and read data
    always_ff @(posedge clk) begin
        if (lookup && cs && hit) begin
            dout <= addr[0] ? line[31:16] : line[15:0];
        end
        if (miss_start) begin
            pend_addr  <= addr;
            // sdram reads are 32 bits wide so the word select is cleared
            fetch_addr <= slot_offset_v + sdram_addr_t'({addr[slot_aw-1:1], 1'b0});
        end
        if (fill) begin
            line <= bus.rdata;
            tag  <= pend_addr[slot_aw-1:1];
            dout <= pend_addr[0] ? bus.rdata[31:16] : bus.rdata[15:0];
        end
    end

    // arbiter only strobes the selected slot while it waits
    a_rdy_needs_sel: assert property (
        @(posedge clk) disable iff (rst)
        bus.rdy |-> (bus.sel && state == st_wait)
    ) else $error("rdy seen without sel or outside a fetch");

    // client must hold its address until ok
    a_addr_held: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_wait) |-> (addr == pend_addr)
    ) else $error("address changed during fetch");

endmodule

`default_nettype wire

/* src/rom_slot_if.sv */
// slot to arbiter link
`default_nettype none
`timescale 1ns/1ps

interface rom_slot_if import rom_pkg::*; ();

    // fetch request, held with addr until rdy
    logic        req;
    // even-aligned sdram word address
    sdram_addr_t addr;

    // high while the arbiter serves this slot
    logic        sel;
    // shared read data, valid on rdy
    sdram_data_t rdata;
    // one-cycle strobe, only for the selected slot
    logic        rdy;

    modport slot (
        output req,
        output addr,
        input  sel,
        input  rdata,
        input  rdy
    );

    modport arbiter (
        input  req,
        input  addr,
        output sel,
        output rdata,
        output rdy
    );

endinterface

`default_nettype wire

/* src/rom_pkg.sv */
// rom slot package
`default_nettype none

package rom_pkg;

    // slot count and address widths
    localparam int num_slots = 3;
    localparam int slot_aw   = 12;
    localparam int sdram_aw  = 22;
    localparam int slot_dw   = 16;
    localparam int sdram_dw  = 32;

    // client side, addresses count 16-bit words
    typedef logic [slot_aw-1:0] slot_addr_t;
    typedef logic [slot_dw-1:0] slot_data_t;

    // sdram side, one read returns two 16-bit words
    typedef logic [sdram_aw-1:0] sdram_addr_t;
    typedef logic [sdram_dw-1:0] sdram_data_t;

    // one-hot grant, bit 0 has the highest priority
    typedef logic [num_slots-1:0] slot_sel_t;

    // each slot reads its own disjoint sdram region
    localparam sdram_addr_t slot_offset [num_slots] = '{
        22'h000000,
        22'h100000,
        22'h200000
    };

    // slot FSM
    // st_fill is the cycle in which a fetched word is handed to the client
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_fill
    } slot_state_t;

    // arbiter FSM
    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_t;

endpackage

`default_nettype wire
